//--- logic/dma_pkg.sv
package dma_pkg;

   // ========================================
   // bus widths
   // ========================================
   typedef logic [31:0] addr_t;
   typedef logic [63:0] data_t;
   typedef logic [7:0]  strb_t;
   typedef logic [3:0]  bus_tag_t;

   // axi size codes, upper bit unused
   typedef enum logic [2:0] {
      SZ_BYTE  = 3'd0,
      SZ_HALF  = 3'd1,
      SZ_WORD  = 3'd2,
      SZ_DWORD = 3'd3
   } dma_size_e;

   // ========================================
   // buffer entry status
   // ========================================
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_QUEUED,
      ST_PENDING,
      ST_DONE
   } entry_state_e;

   typedef enum logic [1:0] {
      ERR_NONE,
      ERR_ALIGN,
      ERR_ECC,
      ERR_ADDR
   } dma_err_e;

   typedef enum logic [1:0] {
      OKAY   = 2'd0,
      SLVERR = 2'd2,
      DECERR = 2'd3
   } axi_resp_e;

endpackage

//--- logic/dma_access_check.sv
`timescale 1ns/1ps

module dma_access_check import dma_pkg::*; #(
   parameter addr_t DCCM_BASE = 32'hF004_0000,
   parameter addr_t DCCM_SIZE = 32'h0001_0000
) (
   input  addr_t     head_addr,
   input  dma_size_e head_sz,
   input  strb_t     head_strb,
   input  logic      head_write,
   output logic      addr_err,
   output logic      align_err,
   output addr_t     mem_addr,
   output dma_size_e mem_sz
);

   logic  in_dccm;
   logic  misalign, bad_wr_sz, bad_word_strb, bad_dword_strb;
   logic  lo_half, hi_half;
   addr_t offset;

   // offset wraps below base, so one compare covers both ends
   assign offset   = head_addr - DCCM_BASE;
   assign in_dccm  = (offset < DCCM_SIZE);
   assign addr_err = ~in_dccm;

   assign misalign = ((head_sz == SZ_HALF) & head_addr[0]) |
                     ((head_sz == SZ_WORD) & (|head_addr[1:0])) |
                     ((head_sz == SZ_DWORD) & (|head_addr[2:0]));

   // dccm only takes word and dword writes
   assign bad_wr_sz = head_write & ((head_sz == SZ_BYTE) | (head_sz == SZ_HALF));

   assign bad_word_strb = head_write & (head_sz == SZ_WORD) &
                          (head_strb[{head_addr[2], 2'b00} +: 4] != 4'hf);

   assign lo_half = (head_strb == 8'h0f);
   assign hi_half = (head_strb == 8'hf0);

   assign bad_dword_strb = head_write & (head_sz == SZ_DWORD) &
                           ~(lo_half | hi_half | (head_strb == 8'hff));

   assign align_err = in_dccm & (misalign | bad_wr_sz | bad_word_strb | bad_dword_strb);

   // ========================================
   // half-dword writes go out as a word
   // ========================================
   assign mem_sz   = (head_write & (lo_half | hi_half)) ? SZ_WORD : head_sz;
   assign mem_addr = (head_write & hi_half) ? {head_addr[31:3], 1'b1, head_addr[1:0]}
                                            : head_addr;

endmodule

//--- logic/dma_cmd_decode.sv
`timescale 1ns/1ps

module dma_cmd_decode import dma_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       dma_axi_awvalid,
   input  bus_tag_t   dma_axi_awid,
   input  addr_t      dma_axi_awaddr,
   input  logic [2:0] dma_axi_awsize,
   input  logic       dma_axi_wvalid,
   input  data_t      dma_axi_wdata,
   input  strb_t      dma_axi_wstrb,
   input  logic       dma_axi_arvalid,
   input  bus_tag_t   dma_axi_arid,
   input  addr_t      dma_axi_araddr,
   input  logic [2:0] dma_axi_arsize,
   input  logic       buf_full,
   output logic       dma_axi_awready,
   output logic       dma_axi_wready,
   output logic       dma_axi_arready,
   output logic       cmd_valid,
   output logic       cmd_write,
   output addr_t      cmd_addr,
   output dma_size_e  cmd_sz,
   output data_t      cmd_wdata,
   output strb_t      cmd_strb,
   output bus_tag_t   cmd_tag
);

   logic      aw_vld, w_vld, ar_vld;
   logic      aw_xfer, w_xfer, ar_xfer;
   logic      cmd_sent, wr_sent, rd_sent;
   logic      wr_ready_cmd, prio;
   addr_t     aw_addr, ar_addr;
   dma_size_e aw_sz, ar_sz;
   bus_tag_t  aw_tag, ar_tag;
   data_t     w_data;
   strb_t     w_strb;

   assign aw_xfer = dma_axi_awvalid & dma_axi_awready;
   assign w_xfer  = dma_axi_wvalid & dma_axi_wready;
   assign ar_xfer = dma_axi_arvalid & dma_axi_arready;

   // write needs both address and data beats
   assign wr_ready_cmd = aw_vld & w_vld;
   assign cmd_valid    = wr_ready_cmd | ar_vld;
   assign cmd_write    = (wr_ready_cmd & ar_vld) ? prio : wr_ready_cmd;
   assign cmd_sent     = cmd_valid & ~buf_full;
   assign wr_sent      = cmd_sent & cmd_write;
   assign rd_sent      = cmd_sent & ~cmd_write;

   assign cmd_addr  = cmd_write ? aw_addr : ar_addr;
   assign cmd_sz    = cmd_write ? aw_sz : ar_sz;
   assign cmd_tag   = cmd_write ? aw_tag : ar_tag;
   assign cmd_wdata = w_data;
   assign cmd_strb  = w_strb;

   assign dma_axi_awready = ~(aw_vld & ~wr_sent);
   assign dma_axi_wready  = ~(w_vld & ~wr_sent);
   assign dma_axi_arready = ~(ar_vld & ~rd_sent);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         aw_vld <= 1'b0;
         w_vld  <= 1'b0;
         ar_vld <= 1'b0;
         prio   <= 1'b0;
      end else begin
         // a new beat on the send cycle keeps the flag set
         aw_vld <= aw_xfer | (aw_vld & ~wr_sent);
         w_vld  <= w_xfer | (w_vld & ~wr_sent);
         ar_vld <= ar_xfer | (ar_vld & ~rd_sent);
         if (cmd_sent) begin
            prio <= ~prio;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (aw_xfer) begin
         aw_addr <= dma_axi_awaddr;
         aw_sz   <= dma_size_e'(dma_axi_awsize);
         aw_tag  <= dma_axi_awid;
      end
      if (w_xfer) begin
         w_data <= dma_axi_wdata;
         w_strb <= dma_axi_wstrb;
      end
      if (ar_xfer) begin
         ar_addr <= dma_axi_araddr;
         ar_sz   <= dma_size_e'(dma_axi_arsize);
         ar_tag  <= dma_axi_arid;
      end
   end

   a_cmd_held : assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && !cmd_sent |=> cmd_valid);

endmodule

//--- logic/dma_buffer.sv
`timescale 1ns/1ps

module dma_buffer import dma_pkg::*; #(
   parameter int DEPTH = 4
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     cmd_valid,
   input  logic                     cmd_write,
   input  addr_t                    cmd_addr,
   input  dma_size_e                cmd_sz,
   input  data_t                    cmd_wdata,
   input  strb_t                    cmd_strb,
   input  bus_tag_t                 cmd_tag,
   input  logic                     addr_err,
   input  logic                     align_err,
   input  addr_t                    mem_addr,
   input  dma_size_e                mem_sz,
   input  logic                     dccm_ready,
   input  logic                     dccm_dma_rvalid,
   input  logic [$clog2(DEPTH)-1:0] dccm_dma_rtag,
   input  data_t                    dccm_dma_rdata,
   input  logic                     dccm_dma_ecc_error,
   input  logic                     rsp_sent,
   output logic                     buf_full,
   output addr_t                    head_addr,
   output dma_size_e                head_sz,
   output strb_t                    head_strb,
   output logic                     head_write,
   output logic                     dma_mem_req,
   output logic [$clog2(DEPTH)-1:0] dma_mem_tag,
   output addr_t                    dma_mem_addr,
   output logic [2:0]               dma_mem_sz,
   output logic                     dma_mem_write,
   output data_t                    dma_mem_wdata,
   output logic                     rsp_valid,
   output logic                     rsp_write,
   output bus_tag_t                 rsp_tag,
   output data_t                    rsp_data,
   output dma_err_e                 rsp_err
);

   localparam int PTR_W = $clog2(DEPTH);

   entry_state_e st [DEPTH];
   addr_t        e_addr [DEPTH];
   dma_size_e    e_sz [DEPTH];
   strb_t        e_strb [DEPTH];
   logic         e_write [DEPTH];
   bus_tag_t     e_tag [DEPTH];
   data_t        e_data [DEPTH];
   dma_err_e     e_err [DEPTH];

   logic [PTR_W-1:0] wr_ptr, rd_ptr, rsp_ptr;
   logic [PTR_W+1:0] num_vld;
   logic             cmd_sent, head_queued, head_err;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign cmd_sent = cmd_valid & ~buf_full;

   // ========================================
   // issue side
   // ========================================
   assign head_addr   = e_addr[rd_ptr];
   assign head_sz     = e_sz[rd_ptr];
   assign head_strb   = e_strb[rd_ptr];
   assign head_write  = e_write[rd_ptr];
   assign head_queued = (st[rd_ptr] == ST_QUEUED);
   assign head_err    = head_queued & (addr_err | align_err);

   assign dma_mem_req   = head_queued & ~(addr_err | align_err) & dccm_ready;
   assign dma_mem_tag   = rd_ptr;
   assign dma_mem_addr  = mem_addr;
   assign dma_mem_sz    = mem_sz;
   assign dma_mem_write = e_write[rd_ptr];
   assign dma_mem_wdata = e_data[rd_ptr];

   assign rsp_valid = (st[rsp_ptr] == ST_DONE);
   assign rsp_write = e_write[rsp_ptr];
   assign rsp_tag   = e_tag[rsp_ptr];
   assign rsp_data  = e_data[rsp_ptr];
   assign rsp_err   = e_err[rsp_ptr];

   // occupancy one cycle ahead, registered into buf_full
   always_comb begin
      num_vld = (PTR_W + 2)'(cmd_sent) - (PTR_W + 2)'(rsp_sent);
      for (int i = 0; i < DEPTH; i++) begin
         num_vld += (PTR_W + 2)'(st[i] != ST_IDLE);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            st[i] <= ST_IDLE;
         end
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         rsp_ptr  <= '0;
         buf_full <= 1'b0;
      end else begin
         buf_full <= (num_vld >= (PTR_W + 2)'(DEPTH));
         if (cmd_sent) begin
            st[wr_ptr] <= ST_QUEUED;
            wr_ptr     <= ptr_inc(wr_ptr);
         end
         if (head_err | dma_mem_req) begin
            st[rd_ptr] <= (head_err | e_write[rd_ptr]) ? ST_DONE : ST_PENDING;
            rd_ptr     <= ptr_inc(rd_ptr);
         end
         if (dccm_dma_rvalid) begin
            st[dccm_dma_rtag] <= ST_DONE;
         end
         if (rsp_sent) begin
            st[rsp_ptr] <= ST_IDLE;
            rsp_ptr     <= ptr_inc(rsp_ptr);
         end
      end
   end

   // entry payload and error record
   always_ff @(posedge clk) begin
      if (cmd_sent) begin
         e_addr[wr_ptr]  <= cmd_addr;
         e_sz[wr_ptr]    <= cmd_sz;
         e_strb[wr_ptr]  <= cmd_strb;
         e_write[wr_ptr] <= cmd_write;
         e_tag[wr_ptr]   <= cmd_tag;
         e_data[wr_ptr]  <= cmd_wdata;
         e_err[wr_ptr]   <= ERR_NONE;
      end
      if (head_err) begin
         e_err[rd_ptr]  <= addr_err ? ERR_ADDR : ERR_ALIGN;
         e_data[rd_ptr] <= {32'b0, e_addr[rd_ptr]};
      end
      if (dccm_dma_rvalid) begin
         e_err[dccm_dma_rtag]  <= dccm_dma_ecc_error ? ERR_ECC : ERR_NONE;
         e_data[dccm_dma_rtag] <= dccm_dma_ecc_error ? {32'b0, e_addr[dccm_dma_rtag]}
                                                     : dccm_dma_rdata;
      end
   end

   a_wr_free : assert property (@(posedge clk) disable iff (!rst_n)
      cmd_sent |-> st[wr_ptr] == ST_IDLE);

   a_rtag_pending : assert property (@(posedge clk) disable iff (!rst_n)
      dccm_dma_rvalid |-> st[dccm_dma_rtag] == ST_PENDING);

endmodule

//--- logic/dma_rsp_return.sv
`timescale 1ns/1ps

module dma_rsp_return import dma_pkg::*; (
   input  logic      rsp_valid,
   input  logic      rsp_write,
   input  bus_tag_t  rsp_tag,
   input  data_t     rsp_data,
   input  dma_err_e  rsp_err,
   input  logic      dma_axi_bready,
   input  logic      dma_axi_rready,
   output logic      dma_axi_bvalid,
   output axi_resp_e dma_axi_bresp,
   output bus_tag_t  dma_axi_bid,
   output logic      dma_axi_rvalid,
   output axi_resp_e dma_axi_rresp,
   output bus_tag_t  dma_axi_rid,
   output data_t     dma_axi_rdata,
   output logic      dma_axi_rlast,
   output logic      rsp_sent
);

   axi_resp_e resp;

   always_comb begin
      case (rsp_err)
         ERR_ALIGN, ERR_ECC: resp = SLVERR;
         ERR_ADDR:           resp = DECERR;
         default:            resp = OKAY;
      endcase
   end

   // write results go to B, reads to R
   assign dma_axi_bvalid = rsp_valid & rsp_write;
   assign dma_axi_bresp  = resp;
   assign dma_axi_bid    = rsp_tag;
   assign dma_axi_rvalid = rsp_valid & ~rsp_write;
   assign dma_axi_rresp  = resp;
   assign dma_axi_rid    = rsp_tag;
   assign dma_axi_rdata  = rsp_data;
   assign dma_axi_rlast  = 1'b1;

   assign rsp_sent = (dma_axi_bvalid & dma_axi_bready) | (dma_axi_rvalid & dma_axi_rready);

endmodule

//--- logic/dma_ctrl.sv
`timescale 1ns/1ps

module dma_ctrl import dma_pkg::*; #(
   parameter int    DEPTH     = 4,
   parameter addr_t DCCM_BASE = 32'hF004_0000,
   parameter addr_t DCCM_SIZE = 32'h0001_0000
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     dma_axi_awvalid,
   output logic                     dma_axi_awready,
   input  bus_tag_t                 dma_axi_awid,
   input  addr_t                    dma_axi_awaddr,
   input  logic [2:0]               dma_axi_awsize,
   input  logic                     dma_axi_wvalid,
   output logic                     dma_axi_wready,
   input  data_t                    dma_axi_wdata,
   input  strb_t                    dma_axi_wstrb,
   output logic                     dma_axi_bvalid,
   input  logic                     dma_axi_bready,
   output logic [1:0]               dma_axi_bresp,
   output bus_tag_t                 dma_axi_bid,
   input  logic                     dma_axi_arvalid,
   output logic                     dma_axi_arready,
   input  bus_tag_t                 dma_axi_arid,
   input  addr_t                    dma_axi_araddr,
   input  logic [2:0]               dma_axi_arsize,
   output logic                     dma_axi_rvalid,
   input  logic                     dma_axi_rready,
   output bus_tag_t                 dma_axi_rid,
   output data_t                    dma_axi_rdata,
   output logic [1:0]               dma_axi_rresp,
   output logic                     dma_axi_rlast,
   output logic                     dma_mem_req,
   output logic [$clog2(DEPTH)-1:0] dma_mem_tag,
   output addr_t                    dma_mem_addr,
   output logic [2:0]               dma_mem_sz,
   output logic                     dma_mem_write,
   output data_t                    dma_mem_wdata,
   input  logic                     dccm_ready,
   input  logic                     dccm_dma_rvalid,
   input  logic [$clog2(DEPTH)-1:0] dccm_dma_rtag,
   input  data_t                    dccm_dma_rdata,
   input  logic                     dccm_dma_ecc_error
);

   // command path
   logic      cmd_valid, cmd_write, buf_full;
   addr_t     cmd_addr;
   dma_size_e cmd_sz;
   data_t     cmd_wdata;
   strb_t     cmd_strb;
   bus_tag_t  cmd_tag;

   // head entry check
   addr_t     head_addr, mem_addr;
   dma_size_e head_sz, mem_sz;
   strb_t     head_strb;
   logic      head_write, addr_err, align_err;

   // response path
   logic      rsp_valid, rsp_write, rsp_sent;
   bus_tag_t  rsp_tag;
   data_t     rsp_data;
   dma_err_e  rsp_err;
   axi_resp_e bresp, rresp;

   assign dma_axi_bresp = bresp;
   assign dma_axi_rresp = rresp;

   dma_cmd_decode u_cmd_decode (
      .clk, .rst_n,
      .dma_axi_awvalid, .dma_axi_awid, .dma_axi_awaddr, .dma_axi_awsize,
      .dma_axi_wvalid, .dma_axi_wdata, .dma_axi_wstrb,
      .dma_axi_arvalid, .dma_axi_arid, .dma_axi_araddr, .dma_axi_arsize,
      .buf_full,
      .dma_axi_awready, .dma_axi_wready, .dma_axi_arready,
      .cmd_valid, .cmd_write, .cmd_addr, .cmd_sz, .cmd_wdata, .cmd_strb, .cmd_tag
   );

   dma_buffer #(.DEPTH(DEPTH)) u_buffer (
      .clk, .rst_n,
      .cmd_valid, .cmd_write, .cmd_addr, .cmd_sz, .cmd_wdata, .cmd_strb, .cmd_tag,
      .addr_err, .align_err, .mem_addr, .mem_sz,
      .dccm_ready, .dccm_dma_rvalid, .dccm_dma_rtag, .dccm_dma_rdata, .dccm_dma_ecc_error,
      .rsp_sent, .buf_full,
      .head_addr, .head_sz, .head_strb, .head_write,
      .dma_mem_req, .dma_mem_tag, .dma_mem_addr, .dma_mem_sz, .dma_mem_write,
      .dma_mem_wdata,
      .rsp_valid, .rsp_write, .rsp_tag, .rsp_data, .rsp_err
   );

   dma_access_check #(.DCCM_BASE(DCCM_BASE), .DCCM_SIZE(DCCM_SIZE)) u_access_check (
      .head_addr, .head_sz, .head_strb, .head_write,
      .addr_err, .align_err, .mem_addr, .mem_sz
   );

   dma_rsp_return u_rsp_return (
      .rsp_valid, .rsp_write, .rsp_tag, .rsp_data, .rsp_err,
      .dma_axi_bready, .dma_axi_rready,
      .dma_axi_bvalid, .dma_axi_bresp(bresp), .dma_axi_bid,
      .dma_axi_rvalid, .dma_axi_rresp(rresp), .dma_axi_rid, .dma_axi_rdata,
      .dma_axi_rlast, .rsp_sent
   );

endmodule

//--- dv/dma_ctrl_tb.sv
`timescale 1ns/1ps

module dma_ctrl_tb import dma_pkg::*; ();

   localparam int    DEPTH       = 4;
   localparam int    MAX_LINES   = 64;
   localparam int    HOLD_CYCLES = 40;
   localparam addr_t DCCM_BASE   = 32'hF004_0000;
   localparam addr_t DCCM_SIZE   = 32'h0001_0000;
   localparam addr_t POISON_ADDR = 32'hF004_0800;

   logic       clk, rst_n;
   logic       dma_axi_awvalid, dma_axi_awready, dma_axi_wvalid, dma_axi_wready;
   logic       dma_axi_bvalid, dma_axi_bready, dma_axi_arvalid, dma_axi_arready;
   logic       dma_axi_rvalid, dma_axi_rready, dma_axi_rlast;
   bus_tag_t   dma_axi_awid, dma_axi_bid, dma_axi_arid, dma_axi_rid;
   addr_t      dma_axi_awaddr, dma_axi_araddr, dma_mem_addr;
   logic [2:0] dma_axi_awsize, dma_axi_arsize, dma_mem_sz;
   data_t      dma_axi_wdata, dma_axi_rdata, dma_mem_wdata, dccm_dma_rdata;
   strb_t      dma_axi_wstrb;
   logic [1:0] dma_axi_bresp, dma_axi_rresp;
   logic       dma_mem_req, dma_mem_write, dccm_ready, dccm_dma_rvalid, dccm_dma_ecc_error;
   logic [$clog2(DEPTH)-1:0] dma_mem_tag, dccm_dma_rtag;

   // one entry per trace line
   logic [7:0] tr_op [MAX_LINES];
   bus_tag_t   tr_id [MAX_LINES];
   addr_t      tr_addr [MAX_LINES];
   logic [2:0] tr_size [MAX_LINES];
   data_t      tr_data [MAX_LINES];
   strb_t      tr_strb [MAX_LINES];
   logic [1:0] tr_resp [MAX_LINES];
   data_t      tr_rdata [MAX_LINES];
   int         n_lines;

   bus_tag_t    exp_bid_q[$], exp_rid_q[$];
   logic [1:0]  exp_bresp_q[$], exp_rresp_q[$];
   data_t       exp_rdata_q[$];
   logic [28:0] bad_dword_q[$];

   // dccm model state
   data_t mem [8192];
   logic [$clog2(DEPTH)-1:0] ret_tag_q[$];
   data_t ret_data_q[$];
   logic  ret_ecc_q[$];
   int    ret_due_q[$];

   int cycles, limit, hold_until, issued, answered;
   int aw_cnt, b_cnt, peak_aw, last_due;

   dma_ctrl #(
      .DEPTH(DEPTH),
      .DCCM_BASE(DCCM_BASE),
      .DCCM_SIZE(DCCM_SIZE)
   ) u_dma_ctrl (.*);

   always #50 clk = ~clk;

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic load_trace();
      int    fd;
      int    n;
      string line;
      fd = $fopen("dv/dma_trace.txt", "r");
      assert (fd != 0) else report_failure("could not open the trace file dv/dma_trace.txt");
      n_lines = 0;
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%c %h %h %h %h %h %h %h", tr_op[n_lines], tr_id[n_lines],
                        tr_addr[n_lines], tr_size[n_lines], tr_data[n_lines],
                        tr_strb[n_lines], tr_resp[n_lines], tr_rdata[n_lines]);
            assert (n == 8) else report_failure({"malformed trace line: ", line});
            n_lines++;
         end
      end
      $fclose(fd);
   endtask

   // ========================================
   // axi driver
   // ========================================
   task automatic send_aw(input int i);
      @(posedge clk);
      dma_axi_awvalid <= 1'b1;
      dma_axi_awid    <= tr_id[i];
      dma_axi_awaddr  <= tr_addr[i];
      dma_axi_awsize  <= tr_size[i];
      @(negedge clk);
      while (!dma_axi_awready) @(negedge clk);
      @(posedge clk);
      dma_axi_awvalid <= 1'b0;
   endtask

   task automatic send_w(input int i);
      @(posedge clk);
      dma_axi_wvalid <= 1'b1;
      dma_axi_wdata  <= tr_data[i];
      dma_axi_wstrb  <= tr_strb[i];
      @(negedge clk);
      while (!dma_axi_wready) @(negedge clk);
      @(posedge clk);
      dma_axi_wvalid <= 1'b0;
   endtask

   task automatic send_ar(input int i);
      @(posedge clk);
      dma_axi_arvalid <= 1'b1;
      dma_axi_arid    <= tr_id[i];
      dma_axi_araddr  <= tr_addr[i];
      dma_axi_arsize  <= tr_size[i];
      @(negedge clk);
      while (!dma_axi_arready) @(negedge clk);
      @(posedge clk);
      dma_axi_arvalid <= 1'b0;
   endtask

   task automatic wait_idle();
      @(negedge clk);
      while (answered != issued) @(negedge clk);
   endtask

   task automatic run_line(input int i);
      case (tr_op[i])
         "W": begin
            exp_bid_q.push_back(tr_id[i]);
            exp_bresp_q.push_back(tr_resp[i]);
            issued++;
            // aw and w run on their own
            fork
               send_aw(i);
               send_w(i);
            join
         end
         "R": begin
            exp_rid_q.push_back(tr_id[i]);
            exp_rresp_q.push_back(tr_resp[i]);
            exp_rdata_q.push_back(tr_rdata[i]);
            issued++;
            send_ar(i);
         end
         "S": wait_idle();
         "H": begin
            @(negedge clk);
            hold_until = cycles + HOLD_CYCLES;
         end
         default: report_failure($sformatf("unknown operation on trace line %0d", i));
      endcase
   endtask

   // ========================================
   // dccm model and response checker
   // ========================================
   task automatic accept_mem_req();
      int    idx;
      int    due;
      strb_t strb;
      assert (dma_mem_addr - DCCM_BASE < DCCM_SIZE)
         else report_failure($sformatf("DCCM request outside the window at 0x%h", dma_mem_addr));
      foreach (bad_dword_q[k]) begin
         assert (bad_dword_q[k] != dma_mem_addr[31:3])
            else report_failure($sformatf("DCCM request at 0x%h for a failing access",
                                          dma_mem_addr));
      end
      idx = int'((dma_mem_addr - DCCM_BASE) >> 3);
      if (dma_mem_write) begin
         strb = strb_t'((9'h1 << (1 << dma_mem_sz)) - 9'h1);
         strb = strb << dma_mem_addr[2:0];
         for (int b = 0; b < 8; b++) begin
            if (strb[b])
               mem[idx][b*8 +: 8] = dma_mem_wdata[b*8 +: 8];
         end
      end else begin
         // returns stay in request order
         due = cycles + 1 + int'($urandom % 4);
         if (due <= last_due)
            due = last_due + 1;
         last_due = due;
         ret_tag_q.push_back(dma_mem_tag);
         ret_data_q.push_back(mem[idx]);
         ret_ecc_q.push_back(dma_mem_addr[31:3] == POISON_ADDR[31:3]);
         ret_due_q.push_back(due);
      end
   endtask

   task automatic check_b();
      assert (exp_bid_q.size() > 0) else report_failure("write response with no write outstanding");
      assert (dma_axi_bid == exp_bid_q[0])
         else report_failure($sformatf("error: dma_axi_bid 0x%h, expected 0x%h",
                                       dma_axi_bid, exp_bid_q[0]));
      assert (dma_axi_bresp == exp_bresp_q[0])
         else report_failure($sformatf("error: dma_axi_bresp 0x%h, expected 0x%h",
                                       dma_axi_bresp, exp_bresp_q[0]));
      void'(exp_bid_q.pop_front());
      void'(exp_bresp_q.pop_front());
      b_cnt++;
      answered++;
   endtask

   task automatic check_r();
      assert (exp_rid_q.size() > 0) else report_failure("read response with no read outstanding");
      assert (dma_axi_rid == exp_rid_q[0])
         else report_failure($sformatf("error: dma_axi_rid 0x%h, expected 0x%h",
                                       dma_axi_rid, exp_rid_q[0]));
      assert (dma_axi_rresp == exp_rresp_q[0])
         else report_failure($sformatf("error: dma_axi_rresp 0x%h, expected 0x%h",
                                       dma_axi_rresp, exp_rresp_q[0]));
      assert (dma_axi_rdata == exp_rdata_q[0])
         else report_failure($sformatf("error: dma_axi_rdata 0x%h, expected 0x%h",
                                       dma_axi_rdata, exp_rdata_q[0]));
      assert (dma_axi_rlast == 1'b1)
         else report_failure($sformatf("error: dma_axi_rlast 0x%h, expected 0x1", dma_axi_rlast));
      void'(exp_rid_q.pop_front());
      void'(exp_rresp_q.pop_front());
      void'(exp_rdata_q.pop_front());
      answered++;
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit)
         report_failure($sformatf("the run timed out after %0d cycles", cycles));
      dccm_ready <= ($urandom % 4) != 0;
      if (cycles < hold_until) begin
         dma_axi_bready <= 1'b0;
         dma_axi_rready <= 1'b0;
      end else begin
         dma_axi_bready <= ($urandom % 3) != 0;
         dma_axi_rready <= ($urandom % 3) != 0;
      end
      if (ret_due_q.size() > 0 && ret_due_q[0] <= cycles) begin
         dccm_dma_rvalid    <= 1'b1;
         dccm_dma_rtag      <= ret_tag_q.pop_front();
         dccm_dma_rdata     <= ret_data_q.pop_front();
         dccm_dma_ecc_error <= ret_ecc_q.pop_front();
         void'(ret_due_q.pop_front());
      end else begin
         dccm_dma_rvalid    <= 1'b0;
         dccm_dma_ecc_error <= 1'b0;
      end
   end

   // sample between edges, transfers happen at the next rising edge
   always @(negedge clk) begin
      if (rst_n) begin
         if (dma_mem_req)
            accept_mem_req();
         if (dma_axi_awvalid && dma_axi_awready)
            aw_cnt++;
         if (dma_axi_bvalid && dma_axi_bready)
            check_b();
         if (dma_axi_rvalid && dma_axi_rready)
            check_r();
         if (aw_cnt - b_cnt > peak_aw)
            peak_aw = aw_cnt - b_cnt;
         assert (aw_cnt - b_cnt <= DEPTH + 1)
            else report_failure($sformatf("%0d write addresses accepted without a response",
                                          aw_cnt - b_cnt));
      end
   end

   initial begin
      void'($urandom(2));
      clk                = 1'b0;
      rst_n              = 1'b0;
      dma_axi_awvalid    = 1'b0;
      dma_axi_awid       = '0;
      dma_axi_awaddr     = '0;
      dma_axi_awsize     = '0;
      dma_axi_wvalid     = 1'b0;
      dma_axi_wdata      = '0;
      dma_axi_wstrb      = '0;
      dma_axi_bready     = 1'b0;
      dma_axi_arvalid    = 1'b0;
      dma_axi_arid       = '0;
      dma_axi_araddr     = '0;
      dma_axi_arsize     = '0;
      dma_axi_rready     = 1'b0;
      dccm_ready         = 1'b0;
      dccm_dma_rvalid    = 1'b0;
      dccm_dma_rtag      = '0;
      dccm_dma_rdata     = '0;
      dccm_dma_ecc_error = 1'b0;
      load_trace();
      limit = 64 * n_lines + 200;
      // fill from the full byte address of each dword
      for (int i = 0; i < 8192; i++) begin
         mem[i] = {~(DCCM_BASE + 32'(i * 8)), DCCM_BASE + 32'(i * 8)};
      end
      for (int i = 0; i < n_lines; i++) begin
         if (tr_resp[i] != 2'd0 && tr_addr[i] != POISON_ADDR)
            bad_dword_q.push_back(tr_addr[i][31:3]);
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < n_lines; i++) begin
         run_line(i);
      end
      wait_idle();
      assert (peak_aw == DEPTH + 1)
         else report_failure("write back-pressure never filled the command buffer");
      $display("Simulation passed");
      $finish;
   end

endmodule

//--- compile.f
logic/dma_pkg.sv
logic/dma_access_check.sv
logic/dma_cmd_decode.sv
logic/dma_buffer.sv
logic/dma_rsp_return.sv
logic/dma_ctrl.sv
dv/dma_ctrl_tb.sv

//--- dv/dma_trace.txt
# op id addr size data strb resp rdata, all hex; op W write, R read
# S waits for all responses, H holds bready and rready low for a while
W 1 f0040000 3 1122334455667788 ff 0 0000000000000000
W 2 f0040008 3 0123456789abcdef ff 0 0000000000000000
W 3 f0040014 2 aabbccdd00000000 f0 0 0000000000000000
S 0 00000000 0 0000000000000000 00 0 0000000000000000
R 4 f0040000 3 0000000000000000 00 0 1122334455667788
R 5 f0040008 3 0000000000000000 00 0 0123456789abcdef
R 6 f0040004 2 0000000000000000 00 0 1122334455667788
R 7 f0040010 3 0000000000000000 00 0 aabbccddf0040010
W 8 f0050000 3 5555555555555555 ff 3 0000000000000000
R 9 f003fff8 3 0000000000000000 00 3 00000000f003fff8
W 9 f0040101 2 0000000012345678 0f 2 0000000000000000
W a f0040108 0 00000000000000ee 01 2 0000000000000000
W b f0040110 1 000000000000beef 03 2 0000000000000000
W c f0040118 3 0000123456780000 3c 2 0000000000000000
W d f0040120 2 0000000012340000 0c 2 0000000000000000
R e f0040122 2 0000000000000000 00 2 00000000f0040122
R f f0040800 3 0000000000000000 00 2 00000000f0040800
S 0 00000000 0 0000000000000000 00 0 0000000000000000
H 0 00000000 0 0000000000000000 00 0 0000000000000000
W 1 f0040200 3 a0a0a0a0a0a0a0a0 ff 0 0000000000000000
W 2 f0040208 3 b1b1b1b1b1b1b1b1 ff 0 0000000000000000
W 3 f0040210 3 c2c2c2c2c2c2c2c2 ff 0 0000000000000000
W 4 f0040218 3 d3d3d3d3d3d3d3d3 ff 0 0000000000000000
W 5 f0040220 3 e4e4e4e4e4e4e4e4 ff 0 0000000000000000
W 6 f0040228 3 f5f5f5f5f5f5f5f5 ff 0 0000000000000000
S 0 00000000 0 0000000000000000 00 0 0000000000000000
W 2 f0040300 3 aaaaaaaabbbbbbbb ff 0 0000000000000000
R 3 f0040200 3 0000000000000000 00 0 a0a0a0a0a0a0a0a0
W 4 f0040308 3 ccccccccdddddddd ff 0 0000000000000000
R 5 f0040218 3 0000000000000000 00 0 d3d3d3d3d3d3d3d3
S 0 00000000 0 0000000000000000 00 0 0000000000000000
W 6 f0040300 3 1111111122222222 0f 0 0000000000000000
R 7 f0040228 3 0000000000000000 00 0 f5f5f5f5f5f5f5f5
W 8 f0040308 3 3333333344444444 f0 0 0000000000000000
S 0 00000000 0 0000000000000000 00 0 0000000000000000
R 9 f0040300 3 0000000000000000 00 0 aaaaaaaa22222222
R a f0040308 3 0000000000000000 00 0 33333333dddddddd
R b f0040210 3 0000000000000000 00 0 c2c2c2c2c2c2c2c2
